// ==== verilog/udp_axi_pkg.sv ====
package udp_axi_pkg;

    localparam logic [7:0] pkt_cmd_tag  = 8'h00;   // command packet / valid header type
    localparam logic [7:0] pkt_data_tag = 8'hff;   // data packet marker
    localparam logic [7:0] resp_tag     = 8'hff;   // top byte of a report word
    localparam logic [3:0] full_strb    = 4'b1111;

    localparam int hdr_fifo_depth   = 16;
    localparam int wdata_fifo_depth = 512;
    localparam int resp_fifo_depth  = 16;
    localparam int resp_cnt_w       = $clog2(resp_fifo_depth + 1);

    // one udp receive word with its end-of-packet flag
    typedef struct packed {
        logic        last;
        logic [31:0] data;
    } rx_word_t;

    // 64-bit write header, high word first on the wire
    typedef struct packed {
        logic [7:0]  tag;
        logic [1:0]  burst;
        logic [1:0]  id;
        logic [2:0]  rsvd_a;
        logic        write;    // 1 = write, 0 = read
        logic [7:0]  len;
        logic [7:0]  rsvd_b;
        logic [31:0] addr;
    } wr_hdr_t;

    typedef struct packed {
        logic [1:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] id;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [7:0] tag;
        logic [5:0] zero_hi;
        logic [1:0] id;
        logic [5:0] zero_mid;
        logic [1:0] resp;
        logic [7:0] zero_lo;
    } resp_word_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                         rstn,
    input  logic                         push,
    input  logic [WIDTH-1:0]             wr_data,
    output logic                         full,
    input  logic                         pop,
    output logic [WIDTH-1:0]             rd_data,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count,
    input  logic                         gmii_rx_clk
);

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    assign full    = (int'(count) == DEPTH);
    assign empty   = (count == '0);
    assign do_push = push && !full;    // pushes into a full fifo are lost
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];      // head word, no read latency

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or simultaneous push/pop
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== verilog/udp_cmd_parser.sv ====
`timescale 1ns/10ps

module udp_cmd_parser (
    input  logic                  gmii_rx_clk,
    input  logic                  rstn,
    input  logic                  rx_en,
    input  udp_axi_pkg::rx_word_t rx_data,
    output logic                  hdr_push,
    output udp_axi_pkg::wr_hdr_t  hdr,
    output logic                  wdata_push,
    output udp_axi_pkg::rx_word_t wdata
);

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for the first word of a packet
        ST_CMD,
        ST_DATA,
        ST_SKIP     // unknown packet, drop to end
    } state_t;

    state_t               state;
    logic                 lo_next;    // next command word is a header low half
    logic [31:0]          hi_word;
    logic [7:0]           top_byte;
    udp_axi_pkg::wr_hdr_t hdr_asm;

    assign top_byte = rx_data.data[31:24];
    assign hdr_asm  = {hi_word, rx_data.data};

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state      <= ST_IDLE;
            lo_next    <= 1'b0;
            hdr_push   <= 1'b0;
            wdata_push <= 1'b0;
        end else begin
            hdr_push   <= 1'b0;
            wdata_push <= 1'b0;
            if (rx_en) begin
                case (state)
                    ST_IDLE: begin
                        lo_next <= 1'b1;    // first word is already a high half
                        if (!rx_data.last) begin
                            if (top_byte == udp_axi_pkg::pkt_cmd_tag) begin
                                state <= ST_CMD;
                            end else if (top_byte == udp_axi_pkg::pkt_data_tag) begin
                                state <= ST_DATA;    // marker word is dropped
                            end else begin
                                state <= ST_SKIP;
                            end
                        end
                    end
                    ST_CMD: begin
                        lo_next <= !lo_next;
                        if (lo_next) begin
                            // only write headers with a command tag go on
                            hdr_push <= (hdr_asm.tag == udp_axi_pkg::pkt_cmd_tag) &&
                                        hdr_asm.write;
                        end
                        if (rx_data.last) begin
                            state <= ST_IDLE;
                        end
                    end
                    ST_DATA: begin
                        wdata_push <= 1'b1;
                        if (rx_data.last) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: begin
                        if (rx_data.last) begin
                            state <= ST_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (rx_en) begin
            if (state == ST_IDLE || (state == ST_CMD && !lo_next)) begin
                hi_word <= rx_data.data;
            end
            if (state == ST_CMD && lo_next) begin
                hdr <= hdr_asm;
            end
            wdata <= rx_data;    // qualified by wdata_push
        end
    end

endmodule

// ==== verilog/axi_wr_addr_ch.sv ====
`timescale 1ns/10ps

module axi_wr_addr_ch (
    input  logic                 gmii_rx_clk,
    input  logic                 rstn,
    input  udp_axi_pkg::wr_hdr_t hdr,
    input  logic                 hdr_empty,
    output logic                 hdr_pop,
    output udp_axi_pkg::axi_aw_t aw,
    output logic                 aw_valid,
    input  logic                 aw_ready
);

    udp_axi_pkg::wr_hdr_t hdr_q;    // header being presented on aw
    logic                 load;

    // take a new header when the slot is free or is being freed now
    assign load    = !hdr_empty && (!aw_valid || aw_ready);
    assign hdr_pop = load;

    assign aw = '{
        id:    hdr_q.id,
        addr:  hdr_q.addr,
        len:   hdr_q.len,
        burst: hdr_q.burst
    };

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            aw_valid <= 1'b0;
        end else if (load) begin
            aw_valid <= 1'b1;
        end else if (aw_ready) begin
            aw_valid <= 1'b0;    // transfer done, nothing queued
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (load) begin
            hdr_q <= hdr;
        end
    end

endmodule

// ==== verilog/axi_wr_data_ch.sv ====
`timescale 1ns/10ps

module axi_wr_data_ch (
    input  logic                  gmii_rx_clk,
    input  logic                  rstn,
    input  udp_axi_pkg::rx_word_t wdata,
    input  logic                  wdata_empty,
    output logic                  wdata_pop,
    output udp_axi_pkg::axi_w_t   w,
    output logic                  w_valid,
    input  logic                  w_ready
);

    logic       xfer;
    logic [8:0] beat_cnt;    // beats of the current burst so far

    assign w_valid   = !wdata_empty;    // fifo head is the beat
    assign xfer      = w_valid && w_ready;
    assign wdata_pop = xfer;

    assign w = '{
        data: wdata.data,
        strb: udp_axi_pkg::full_strb,
        last: wdata.last
    };

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (xfer) begin
            if (wdata.last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/axi_wr_resp_tx.sv ====
`timescale 1ns/10ps

module axi_wr_resp_tx (
    input  logic                gmii_rx_clk,
    input  logic                rstn,
    input  udp_axi_pkg::axi_b_t b,
    input  logic                b_valid,
    output logic                b_ready,
    output logic                udp_tx_start,
    output logic [15:0]         udp_tx_byte_num,
    output logic [31:0]         udp_tx_data,
    input  logic                udp_tx_req,
    input  logic                udp_tx_done
);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t                         tx_state;
    logic                              b_en;        // set once out of reset
    logic                              b_xfer;
    logic                              rpt_push;
    logic                              rpt_pop;
    logic                              rpt_empty;
    udp_axi_pkg::resp_word_t           rpt_word;
    logic [udp_axi_pkg::resp_cnt_w-1:0] rpt_count;
    logic [udp_axi_pkg::resp_cnt_w:0]   level;      // fill incl. word in flight

    assign b_xfer  = b_valid && b_ready;
    assign level   = {1'b0, rpt_count} + {{udp_axi_pkg::resp_cnt_w{1'b0}}, rpt_push};
    assign b_ready = b_en && (int'(level) < udp_axi_pkg::resp_fifo_depth);
    assign rpt_pop = (tx_state == TX_SEND) && udp_tx_req;    // one word per req

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            tx_state        <= TX_IDLE;
            udp_tx_start    <= 1'b0;
            udp_tx_byte_num <= '0;
            b_en            <= 1'b0;
            rpt_push        <= 1'b0;
        end else begin
            b_en         <= 1'b1;
            rpt_push     <= b_xfer;
            udp_tx_start <= 1'b0;
            case (tx_state)
                TX_IDLE: begin
                    if (!rpt_empty) begin
                        udp_tx_start    <= 1'b1;
                        udp_tx_byte_num <= 16'({rpt_count, 2'b00});    // 4 bytes per word
                        tx_state        <= TX_SEND;
                    end
                end
                default: begin
                    if (udp_tx_done) begin
                        tx_state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (b_xfer) begin
            rpt_word <= '{
                tag:      udp_axi_pkg::resp_tag,
                zero_hi:  '0,
                id:       b.id,
                zero_mid: '0,
                resp:     b.resp,
                zero_lo:  '0
            };
        end
    end

    sync_fifo #(
        .WIDTH ($bits(udp_axi_pkg::resp_word_t)),
        .DEPTH (udp_axi_pkg::resp_fifo_depth)
    ) i_rpt_fifo (
        .rstn        (rstn),
        .push        (rpt_push),
        .wr_data     (rpt_word),
        .full        (),
        .pop         (rpt_pop),
        .rd_data     (udp_tx_data),
        .empty       (rpt_empty),
        .count       (rpt_count),
        .gmii_rx_clk (gmii_rx_clk)
    );

endmodule

// ==== verilog/udp_axi_wr_bridge.sv ====
`timescale 1ns/10ps

module udp_axi_wr_bridge (
    input  logic                  gmii_rx_clk,
    input  logic                  rstn,
    input  logic                  rx_en,
    input  udp_axi_pkg::rx_word_t rx_data,
    output udp_axi_pkg::axi_aw_t  aw,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output udp_axi_pkg::axi_w_t   w,
    output logic                  w_valid,
    input  logic                  w_ready,
    input  udp_axi_pkg::axi_b_t   b,
    input  logic                  b_valid,
    output logic                  b_ready,
    output logic                  udp_tx_start,
    output logic [15:0]           udp_tx_byte_num,
    output logic [31:0]           udp_tx_data,
    input  logic                  udp_tx_req,
    input  logic                  udp_tx_done
);

    logic                  hdr_push;
    udp_axi_pkg::wr_hdr_t  hdr_in;
    udp_axi_pkg::wr_hdr_t  hdr_head;
    logic                  hdr_empty;
    logic                  hdr_pop;
    logic                  wdata_push;
    udp_axi_pkg::rx_word_t wdata_in;
    udp_axi_pkg::rx_word_t wdata_head;
    logic                  wdata_empty;
    logic                  wdata_pop;

    udp_cmd_parser i_udp_cmd_parser (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .rx_en       (rx_en),
        .rx_data     (rx_data),
        .hdr_push    (hdr_push),
        .hdr         (hdr_in),
        .wdata_push  (wdata_push),
        .wdata       (wdata_in)
    );

    // write headers waiting for the aw channel
    sync_fifo #(
        .WIDTH ($bits(udp_axi_pkg::wr_hdr_t)),
        .DEPTH (udp_axi_pkg::hdr_fifo_depth)
    ) i_hdr_fifo (
        .rstn        (rstn),
        .push        (hdr_push),
        .wr_data     (hdr_in),
        .full        (),
        .pop         (hdr_pop),
        .rd_data     (hdr_head),
        .empty       (hdr_empty),
        .count       (),
        .gmii_rx_clk (gmii_rx_clk)
    );

    // payload words with their last flag
    sync_fifo #(
        .WIDTH ($bits(udp_axi_pkg::rx_word_t)),
        .DEPTH (udp_axi_pkg::wdata_fifo_depth)
    ) i_wdata_fifo (
        .rstn        (rstn),
        .push        (wdata_push),
        .wr_data     (wdata_in),
        .full        (),
        .pop         (wdata_pop),
        .rd_data     (wdata_head),
        .empty       (wdata_empty),
        .count       (),
        .gmii_rx_clk (gmii_rx_clk)
    );

    axi_wr_addr_ch i_axi_wr_addr_ch (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .hdr         (hdr_head),
        .hdr_empty   (hdr_empty),
        .hdr_pop     (hdr_pop),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready)
    );

    axi_wr_data_ch i_axi_wr_data_ch (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wdata       (wdata_head),
        .wdata_empty (wdata_empty),
        .wdata_pop   (wdata_pop),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready)
    );

    axi_wr_resp_tx i_axi_wr_resp_tx (
        .gmii_rx_clk     (gmii_rx_clk),
        .rstn            (rstn),
        .b               (b),
        .b_valid         (b_valid),
        .b_ready         (b_ready),
        .udp_tx_start    (udp_tx_start),
        .udp_tx_byte_num (udp_tx_byte_num),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
    output logic gmii_rx_clk,
    output logic rstn
);

    localparam int period_ns    = 40;
    localparam int reset_cycles = 10;

    initial begin
        gmii_rx_clk = 1'b0;
        forever #(period_ns / 2) gmii_rx_clk = ~gmii_rx_clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge gmii_rx_clk);
        #2;
        rstn = 1'b1;    // released off the clock edge
    end

endmodule

// ==== sim/tb_udp_axi_wr.sv ====
`timescale 1ns/10ps

module tb_udp_axi_wr;

    localparam int period_ns    = 40;
    localparam int reset_cycles = 10;
    localparam int n_xfers      = 1 + 1 + 6 + 4 + 13 + 20;    // all tests together

    logic                  gmii_rx_clk;
    logic                  rstn;
    logic                  rx_en;
    udp_axi_pkg::rx_word_t rx_data;
    udp_axi_pkg::axi_aw_t  aw;
    logic                  aw_valid;
    logic                  aw_ready;
    udp_axi_pkg::axi_w_t   w;
    logic                  w_valid;
    logic                  w_ready;
    udp_axi_pkg::axi_b_t   b;
    logic                  b_valid;
    logic                  b_ready;
    logic                  udp_tx_start;
    logic [15:0]           udp_tx_byte_num;
    logic [31:0]           udp_tx_data;
    logic                  udp_tx_req;
    logic                  udp_tx_done;

    logic [15:0]           lfsr_state;
    logic                  stall_en;       // random ready stalls on aw and w
    int                    b_todo;         // responses still to issue
    logic                  b_taken;
    logic                  tx_busy;
    logic [15:0]           batch_bytes;
    int                    mismatch_cnt;
    int                    fail_cnt;
    logic [43:0]           exp_aw[$];
    logic [36:0]           exp_w[$];
    logic [31:0]           exp_rpt[$];
    logic [31:0]           pkt[$];         // words of the next rx packet
    logic                  aw_hold;
    logic                  w_hold;
    udp_axi_pkg::axi_aw_t  aw_prev;
    udp_axi_pkg::axi_w_t   w_prev;
    int                    rpt_fill;       // expected report fifo fill level
    int                    fill_prev;      // fill level one edge earlier
    logic                  b_push_d;       // b transfer seen on the previous edge

    tb_clk_gen i_tb_clk_gen (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn)
    );

    udp_axi_wr_bridge i_udp_axi_wr_bridge (
        .gmii_rx_clk     (gmii_rx_clk),
        .rstn            (rstn),
        .rx_en           (rx_en),
        .rx_data         (rx_data),
        .aw              (aw),
        .aw_valid        (aw_valid),
        .aw_ready        (aw_ready),
        .w               (w),
        .w_valid         (w_valid),
        .w_ready         (w_ready),
        .b               (b),
        .b_valid         (b_valid),
        .b_ready         (b_ready),
        .udp_tx_start    (udp_tx_start),
        .udp_tx_byte_num (udp_tx_byte_num),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done)
    );

    // fibonacci lfsr x^16+x^14+x^13+x^11 stepped once per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            r = {r[6:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [43:0] header_to_aw(input udp_axi_pkg::wr_hdr_t h);
        return {h.id, h.addr, h.len, h.burst};
    endfunction

    function automatic logic [36:0] word_to_w(input logic [31:0] data, input logic last);
        return {data, 4'hf, last};    // all byte lanes enabled
    endfunction

    function automatic logic [31:0] resp_to_report(input logic [1:0] id, input logic [1:0] resp);
        return {8'hff, 6'd0, id, 6'd0, resp, 8'd0};
    endfunction

    function automatic udp_axi_pkg::wr_hdr_t make_header(
        input logic [7:0]  tag,
        input logic [1:0]  id,
        input logic        write,
        input logic [7:0]  len,
        input logic [31:0] addr
    );
        udp_axi_pkg::wr_hdr_t h;
        h        = '0;
        h.tag    = tag;
        h.burst  = 2'b01;
        h.id     = id;
        h.rsvd_a = 3'b101;    // reserved bits must be ignored
        h.write  = write;
        h.len    = len;
        h.rsvd_b = 8'h3c;
        h.addr   = addr;
        return h;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_cnt++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic add_header(input udp_axi_pkg::wr_hdr_t h);
        pkt.push_back(h[63:32]);
        pkt.push_back(h[31:0]);
        if (h.tag == 8'h00 && h.write) begin
            exp_aw.push_back(header_to_aw(h));    // only write headers reach aw
        end
    endtask

    task automatic add_data(input int n, input logic [31:0] base);
        logic [31:0] word;
        pkt.push_back(32'hff00_0000);
        for (int i = 0; i < n; i++) begin
            word = base + 32'(i) * 32'h0001_0101;
            pkt.push_back(word);
            exp_w.push_back(word_to_w(word, i == n - 1));
        end
    endtask

    task automatic send_packet();
        for (int i = 0; i < pkt.size(); i++) begin
            @(posedge gmii_rx_clk);
            #2;
            rx_en        = 1'b1;
            rx_data.data = pkt[i];
            rx_data.last = (i == pkt.size() - 1);
        end
        @(posedge gmii_rx_clk);
        #2;
        rx_en   = 1'b0;
        rx_data = '0;
        pkt.delete();
    endtask

    task automatic wait_drain();
        while (exp_aw.size() != 0 || exp_w.size() != 0 || exp_rpt.size() != 0 ||
               b_todo != 0 || tx_busy) begin
            @(posedge gmii_rx_clk);
        end
        repeat (20) @(posedge gmii_rx_clk);    // window for stray transfers
    endtask

    // axi slave with ready stalls and b responses
    always begin
        @(posedge gmii_rx_clk);
        b_taken = b_valid && b_ready;
        #2;
        aw_ready = stall_en ? 1'(rand_bits(1)) : 1'b1;
        w_ready  = stall_en ? 1'(rand_bits(1)) : 1'b1;
        if (b_taken) begin
            b_valid = 1'b0;
        end
        if (!b_valid && b_todo > 0) begin
            if (!stall_en || rand_bits(1) == 8'd1) begin
                b.id    = 2'(rand_bits(2));
                b.resp  = 2'(rand_bits(2));
                b_valid = 1'b1;
                b_todo--;
                exp_rpt.push_back(resp_to_report(b.id, b.resp));
            end
        end
    end

    // udp transmit side gives one req per counted word and then done
    always begin
        @(posedge gmii_rx_clk);
        if (rstn && udp_tx_start) begin
            tx_busy     = 1'b1;
            batch_bytes = udp_tx_byte_num;
            if (batch_bytes == 16'd0 || batch_bytes[1:0] != 2'b00) begin
                report_failure("udp_tx_byte_num is not a positive multiple of 4");
            end
            #2;
            udp_tx_req = 1'b1;
            repeat (int'(batch_bytes) / 4) @(posedge gmii_rx_clk);
            #2;
            udp_tx_req  = 1'b0;
            udp_tx_done = 1'b1;
            @(posedge gmii_rx_clk);
            check_value("udp_tx_byte_num", 64'(udp_tx_byte_num), 64'(batch_bytes));
            #2;
            udp_tx_done = 1'b0;
            tx_busy     = 1'b0;
        end
    end

    // compare observed transfers with the expected queues
    always @(posedge gmii_rx_clk) begin
        if (rstn) begin
            if (aw_hold) begin
                check_value("aw_valid", 64'(aw_valid), 64'(1'b1));
                check_value("aw", 64'(aw), 64'(aw_prev));    // stable while stalled
            end
            if (aw_valid && aw_ready) begin
                if (exp_aw.size() == 0) begin
                    report_failure("aw transfer with no write header pending");
                end else begin
                    check_value("aw", 64'(aw), 64'(exp_aw.pop_front()));
                end
            end
            aw_hold = aw_valid && !aw_ready;
            aw_prev = aw;
            if (w_hold) begin
                check_value("w_valid", 64'(w_valid), 64'(1'b1));
                check_value("w", 64'(w), 64'(w_prev));
            end
            if (w_valid && w_ready) begin
                if (exp_w.size() == 0) begin
                    report_failure("w transfer with no payload word pending");
                end else begin
                    check_value("w", 64'(w), 64'(exp_w.pop_front()));
                end
            end
            w_hold = w_valid && !w_ready;
            w_prev = w;
            if (udp_tx_req) begin
                if (exp_rpt.size() == 0) begin
                    report_failure("report word requested with no response pending");
                end else begin
                    check_value("udp_tx_data", 64'(udp_tx_data), 64'(exp_rpt.pop_front()));
                end
            end
            // byte count is taken from the fill level in the cycle before start
            if (udp_tx_start) begin
                check_value("udp_tx_byte_num", 64'(udp_tx_byte_num), 64'(4 * fill_prev));
            end
            fill_prev = rpt_fill;
            rpt_fill  = rpt_fill + int'(b_push_d) - int'(udp_tx_req);
            b_push_d  = b_valid && b_ready;    // report word lands one cycle later
        end
    end

    initial begin
        #(period_ns * (reset_cycles + 200 * n_xfers));
        report_failure("watchdog timeout, transfers still outstanding");
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        $display("tests failed");
        $finish;
    end

    initial begin
        lfsr_state   = 16'd49870;
        rx_en        = 1'b0;
        rx_data      = '0;
        aw_ready     = 1'b0;
        w_ready      = 1'b0;
        b            = '0;
        b_valid      = 1'b0;
        udp_tx_req   = 1'b0;
        udp_tx_done  = 1'b0;
        stall_en     = 1'b0;
        b_todo       = 0;
        tx_busy      = 1'b0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        aw_hold      = 1'b0;
        w_hold       = 1'b0;
        rpt_fill     = 0;
        fill_prev    = 0;
        b_push_d     = 1'b0;
        @(posedge rstn);
        #1;
        check_value("aw_valid", 64'(aw_valid), 64'(1'b0));
        check_value("w_valid", 64'(w_valid), 64'(1'b0));
        check_value("b_ready", 64'(b_ready), 64'(1'b0));
        check_value("udp_tx_start", 64'(udp_tx_start), 64'(1'b0));

        // single write header
        add_header(make_header(8'h00, 2'd2, 1'b1, 8'd3, 32'h1000_0040));
        send_packet();
        wait_drain();

        // read header and foreign tag are dropped
        add_header(make_header(8'h00, 2'd1, 1'b1, 8'd7, 32'h1000_0100));
        add_header(make_header(8'h00, 2'd3, 1'b0, 8'd1, 32'h1000_0200));
        add_header(make_header(8'h5a, 2'd0, 1'b1, 8'd2, 32'h1000_0300));
        send_packet();
        pkt.push_back(32'h41ff_0000);    // unknown packet type
        pkt.push_back(32'hff00_0000);
        pkt.push_back(32'h0000_0001);
        send_packet();
        wait_drain();

        add_data(6, 32'ha5a5_0000);
        send_packet();
        wait_drain();

        // back-pressure on aw and w
        stall_en = 1'b1;
        for (int i = 0; i < 4; i++) begin
            add_header(make_header(8'h00, 2'(i), 1'b1, 8'(i + 1),
                                   32'h2000_0000 + 32'(i) * 32'h100));
        end
        send_packet();
        add_data(8, 32'h3c00_0010);
        send_packet();
        add_data(5, 32'h7700_0a00);
        send_packet();
        wait_drain();

        b_todo = 20;
        wait_drain();

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/udp_axi_pkg.sv
verilog/sync_fifo.sv
verilog/udp_cmd_parser.sv
verilog/axi_wr_addr_ch.sv
verilog/axi_wr_data_ch.sv
verilog/axi_wr_resp_tx.sv
verilog/udp_axi_wr_bridge.sv
sim/tb_clk_gen.sv
sim/tb_udp_axi_wr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the udp to axi write bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_udp_axi_wr \
    -f files.f \
    -o tb_udp_axi_wr
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_udp_axi_wr > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$log"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail, see $log"
    exit 1
fi
